// ==== tomasulo_pkg.sv ====
package tomasulo_pkg;

    // Widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int tag_w      = 3;
    localparam int op_w       = 5;
    localparam int cls_w      = 2;
    localparam int imm_sel_w  = 3;

    // Station tags, zero means the operand value is present
    localparam logic [tag_w-1:0] tag_none = 3'd0;
    localparam logic [tag_w-1:0] tag_alu1 = 3'd1;
    localparam logic [tag_w-1:0] tag_alu2 = 3'd2;
    localparam logic [tag_w-1:0] tag_mul1 = 3'd3;
    localparam logic [tag_w-1:0] tag_brh1 = 3'd4;

    // Instruction classes
    localparam logic [cls_w-1:0] cls_none = 2'd0;
    localparam logic [cls_w-1:0] cls_alu  = 2'd1;
    localparam logic [cls_w-1:0] cls_mul  = 2'd2;
    localparam logic [cls_w-1:0] cls_jump = 2'd3;

    // ALU operations, bit 4 set on the immediate forms
    localparam logic [op_w-1:0] op_alu_add   = 5'h01;
    localparam logic [op_w-1:0] op_alu_sub   = 5'h02;
    localparam logic [op_w-1:0] op_alu_and   = 5'h03;
    localparam logic [op_w-1:0] op_alu_or    = 5'h04;
    localparam logic [op_w-1:0] op_alu_xor   = 5'h05;
    localparam logic [op_w-1:0] op_alu_sll   = 5'h06;
    localparam logic [op_w-1:0] op_alu_srl   = 5'h07;
    localparam logic [op_w-1:0] op_alu_slt   = 5'h08;
    localparam logic [op_w-1:0] op_alu_sltu  = 5'h09;
    localparam logic [op_w-1:0] op_alu_sra   = 5'h0a;
    localparam logic [op_w-1:0] op_alu_addi  = 5'h11;
    localparam logic [op_w-1:0] op_alu_andi  = 5'h13;
    localparam logic [op_w-1:0] op_alu_ori   = 5'h14;
    localparam logic [op_w-1:0] op_alu_xori  = 5'h15;
    localparam logic [op_w-1:0] op_alu_slli  = 5'h16;
    localparam logic [op_w-1:0] op_alu_srli  = 5'h17;
    localparam logic [op_w-1:0] op_alu_slti  = 5'h18;
    localparam logic [op_w-1:0] op_alu_sltiu = 5'h19;
    localparam logic [op_w-1:0] op_alu_srai  = 5'h1a;
    localparam logic [op_w-1:0] op_alu_lui   = 5'h1b;
    localparam logic [op_w-1:0] op_alu_auipc = 5'h1c;

    // Multiply operations
    localparam logic [op_w-1:0] op_mul_mul    = 5'h00;
    localparam logic [op_w-1:0] op_mul_mulh   = 5'h01;
    localparam logic [op_w-1:0] op_mul_mulhsu = 5'h02;
    localparam logic [op_w-1:0] op_mul_mulhu  = 5'h03;

    // Branch and jump operations
    localparam logic [op_w-1:0] op_jump_beq  = 5'h01;
    localparam logic [op_w-1:0] op_jump_bne  = 5'h02;
    localparam logic [op_w-1:0] op_jump_blt  = 5'h03;
    localparam logic [op_w-1:0] op_jump_bge  = 5'h04;
    localparam logic [op_w-1:0] op_jump_bltu = 5'h05;
    localparam logic [op_w-1:0] op_jump_bgeu = 5'h06;
    localparam logic [op_w-1:0] op_jump_jal  = 5'h07;
    localparam logic [op_w-1:0] op_jump_jalr = 5'h08;

    // Immediate formats for the external generator
    localparam logic [imm_sel_w-1:0] imm_type_i = 3'd1;
    localparam logic [imm_sel_w-1:0] imm_type_s = 3'd2;
    localparam logic [imm_sel_w-1:0] imm_type_b = 3'd3;
    localparam logic [imm_sel_w-1:0] imm_type_u = 3'd4;
    localparam logic [imm_sel_w-1:0] imm_type_j = 3'd5;

    // Major opcodes
    localparam logic [6:0] opc_r     = 7'b0110011;
    localparam logic [6:0] opc_i     = 7'b0010011;
    localparam logic [6:0] opc_b     = 7'b1100011;
    localparam logic [6:0] opc_lui   = 7'b0110111;
    localparam logic [6:0] opc_auipc = 7'b0010111;
    localparam logic [6:0] opc_jal   = 7'b1101111;
    localparam logic [6:0] opc_jalr  = 7'b1100111;

endpackage

// ==== inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
    input  logic [tomasulo_pkg::xlen-1:0]       inst,
    output logic [tomasulo_pkg::cls_w-1:0]      cls,
    output logic [tomasulo_pkg::op_w-1:0]       op,
    output logic [tomasulo_pkg::reg_addr_w-1:0] dst,
    output logic [tomasulo_pkg::reg_addr_w-1:0] src1,
    output logic [tomasulo_pkg::reg_addr_w-1:0] src2,
    output logic [tomasulo_pkg::imm_sel_w-1:0]  imm_sel
);
    import tomasulo_pkg::*;

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;

    assign opcode = inst[6:0];
    assign funct7 = inst[31:25];
    assign funct3 = inst[14:12];

    always_comb begin
        cls     = cls_none;
        op      = '0;
        dst     = '0;
        src1    = '0;
        src2    = '0;
        imm_sel = '0;
        case (opcode)
            opc_r: begin
                cls  = cls_alu;
                dst  = inst[11:7];
                src1 = inst[19:15];
                src2 = inst[24:20];
                case ({funct7, funct3})
                    {7'h00, 3'd0}: op = op_alu_add;
                    {7'h20, 3'd0}: op = op_alu_sub;
                    {7'h00, 3'd1}: op = op_alu_sll;
                    {7'h00, 3'd2}: op = op_alu_slt;
                    {7'h00, 3'd3}: op = op_alu_sltu;
                    {7'h00, 3'd4}: op = op_alu_xor;
                    {7'h00, 3'd5}: op = op_alu_srl;
                    {7'h20, 3'd5}: op = op_alu_sra;
                    {7'h00, 3'd6}: op = op_alu_or;
                    {7'h00, 3'd7}: op = op_alu_and;
                    {7'h01, 3'd0}: op = op_mul_mul;
                    {7'h01, 3'd1}: op = op_mul_mulh;
                    {7'h01, 3'd2}: op = op_mul_mulhsu;
                    {7'h01, 3'd3}: op = op_mul_mulhu;
                    default:       cls = cls_none;
                endcase
                // Divides share funct7 with multiplies and fell to cls_none above
                if (funct7 == 7'h01 && cls != cls_none) begin
                    cls = cls_mul;
                end
            end
            opc_i: begin
                cls     = cls_alu;
                dst     = inst[11:7];
                src1    = inst[19:15];
                imm_sel = imm_type_i;
                case (funct3)
                    3'd0: op = op_alu_addi;
                    3'd2: op = op_alu_slti;
                    3'd3: op = op_alu_sltiu;
                    3'd4: op = op_alu_xori;
                    3'd6: op = op_alu_ori;
                    3'd7: op = op_alu_andi;
                    3'd1: op = (funct7 == 7'h00) ? op_alu_slli : '0;
                    default: op = (funct7 == 7'h00) ? op_alu_srli :
                                  (funct7 == 7'h20) ? op_alu_srai : '0;
                endcase
                if (op == '0) begin
                    cls = cls_none;
                end
            end
            opc_b: begin
                cls     = cls_jump;
                src1    = inst[19:15];
                src2    = inst[24:20];
                imm_sel = imm_type_b;
                case (funct3)
                    3'd0:    op = op_jump_beq;
                    3'd1:    op = op_jump_bne;
                    3'd4:    op = op_jump_blt;
                    3'd5:    op = op_jump_bge;
                    3'd6:    op = op_jump_bltu;
                    3'd7:    op = op_jump_bgeu;
                    default: cls = cls_none;
                endcase
            end
            opc_lui, opc_auipc: begin
                cls     = cls_alu;
                op      = (opcode == opc_lui) ? op_alu_lui : op_alu_auipc;
                dst     = inst[11:7];
                imm_sel = imm_type_u;
            end
            opc_jal: begin
                cls     = cls_jump;
                op      = op_jump_jal;
                dst     = inst[11:7];
                imm_sel = imm_type_j;
            end
            opc_jalr: begin
                cls     = (funct3 == 3'd0) ? cls_jump : cls_none;
                op      = op_jump_jalr;
                dst     = inst[11:7];
                src1    = inst[19:15];
                imm_sel = imm_type_i;
            end
            default: cls = cls_none;
        endcase
        // Nothing escapes for an instruction that will not issue
        if (cls == cls_none) begin
            op      = '0;
            dst     = '0;
            src1    = '0;
            src2    = '0;
            imm_sel = '0;
        end
    end

endmodule

// ==== reg_status_table.sv ====
`timescale 1ns/1ps

module reg_status_table (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [tomasulo_pkg::reg_addr_w-1:0] src1,
    input  logic [tomasulo_pkg::reg_addr_w-1:0] src2,
    input  logic [tomasulo_pkg::reg_addr_w-1:0] dst,
    input  logic [tomasulo_pkg::tag_w-1:0]      wr_tag,
    input  logic                                wr_en,
    input  logic [tomasulo_pkg::tag_w-1:0]      alu_done_tag,
    input  logic [tomasulo_pkg::tag_w-1:0]      mul_done_tag,
    input  logic [tomasulo_pkg::tag_w-1:0]      jump_done_tag,
    output logic [tomasulo_pkg::tag_w-1:0]      q1,
    output logic [tomasulo_pkg::tag_w-1:0]      q2
);
    import tomasulo_pkg::*;

    // Producer tag per architectural register
    logic [tag_w-1:0] rrs [2**reg_addr_w];

    assign q1 = rrs[src1];
    assign q2 = rrs[src2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                rrs[i] <= tag_none;
            end
        end else begin
            // x0 stays at tag_none, so the loop starts at 1
            for (int i = 1; i < 2**reg_addr_w; i++) begin
                if (wr_en && dst == reg_addr_w'(i)) begin
                    rrs[i] <= wr_tag;
                end else if (rrs[i] != tag_none &&
                             (rrs[i] == alu_done_tag || rrs[i] == mul_done_tag ||
                              rrs[i] == jump_done_tag)) begin
                    rrs[i] <= tag_none;
                end
            end
        end
    end

    for (genvar g = 0; g < 2**reg_addr_w; g++) begin : g_chk
        a_tag_range: assert property (@(posedge clk) disable iff (rst) rrs[g] <= tag_brh1)
            else $error("status entry %0d holds tag %0d", g, rrs[g]);
    end

endmodule

// ==== res_station.sv ====
`timescale 1ns/1ps

module res_station #(
    parameter logic [tomasulo_pkg::tag_w-1:0] own_tag = tomasulo_pkg::tag_alu1
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                load,
    input  logic [tomasulo_pkg::op_w-1:0]       op,
    input  logic [tomasulo_pkg::tag_w-1:0]      q1,
    input  logic [tomasulo_pkg::tag_w-1:0]      q2,
    input  logic [tomasulo_pkg::xlen-1:0]       rs1_val,
    input  logic [tomasulo_pkg::xlen-1:0]       rs2_val,
    input  logic [tomasulo_pkg::xlen-1:0]       imm,
    input  logic [tomasulo_pkg::xlen-1:0]       pc,
    input  logic [tomasulo_pkg::reg_addr_w-1:0] rd,
    input  logic [tomasulo_pkg::tag_w-1:0]      alu_done_tag,
    input  logic [tomasulo_pkg::xlen-1:0]       alu_done_val,
    input  logic [tomasulo_pkg::tag_w-1:0]      mul_done_tag,
    input  logic [tomasulo_pkg::xlen-1:0]       mul_done_val,
    input  logic [tomasulo_pkg::tag_w-1:0]      jump_done_tag,
    input  logic [tomasulo_pkg::xlen-1:0]       jump_done_val,
    output logic                                busy,
    output logic                                en,
    output logic [tomasulo_pkg::op_w-1:0]       op_out,
    output logic [tomasulo_pkg::xlen-1:0]       vj,
    output logic [tomasulo_pkg::xlen-1:0]       vk,
    output logic [tomasulo_pkg::xlen-1:0]       imm_out,
    output logic [tomasulo_pkg::xlen-1:0]       pc_out,
    output logic [tomasulo_pkg::reg_addr_w-1:0] rd_out
);
    import tomasulo_pkg::*;

    logic [tag_w-1:0]      qj;
    logic [tag_w-1:0]      qk;
    logic [op_w-1:0]       op_q;
    logic [xlen-1:0]       vj_q;
    logic [xlen-1:0]       vk_q;
    logic [xlen-1:0]       imm_q;
    logic [xlen-1:0]       pc_q;
    logic [reg_addr_w-1:0] rd_q;
    logic                  own_done;

    // True when a pending tag is being broadcast this cycle
    function automatic logic tag_hit(input logic [tag_w-1:0] t);
        return t != tag_none &&
               (t == alu_done_tag || t == mul_done_tag || t == jump_done_tag);
    endfunction

    function automatic logic [xlen-1:0] tag_val(input logic [tag_w-1:0] t);
        if (t == alu_done_tag) begin
            return alu_done_val;
        end else if (t == mul_done_tag) begin
            return mul_done_val;
        end
        return jump_done_val;
    endfunction

    assign own_done = tag_hit(own_tag);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            qj   <= tag_none;
            qk   <= tag_none;
        end else if (load) begin
            busy <= 1'b1;
            qj   <= tag_hit(q1) ? tag_none : q1;
            qk   <= tag_hit(q2) ? tag_none : q2;
        end else begin
            if (own_done) begin
                busy <= 1'b0;
            end
            if (tag_hit(qj)) begin
                qj <= tag_none;
            end
            if (tag_hit(qk)) begin
                qk <= tag_none;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            op_q  <= op;
            vj_q  <= tag_hit(q1) ? tag_val(q1) : rs1_val;
            vk_q  <= tag_hit(q2) ? tag_val(q2) : rs2_val;
            imm_q <= imm;
            pc_q  <= pc;
            rd_q  <= rd;
        end else begin
            if (tag_hit(qj)) begin
                vj_q <= tag_val(qj);
            end
            if (tag_hit(qk)) begin
                vk_q <= tag_val(qk);
            end
        end
    end

    // Ready once both operands are in
    assign en      = busy && qj == tag_none && qk == tag_none;
    assign op_out  = en ? op_q : '0;
    assign vj      = en ? vj_q : '0;
    assign vk      = en ? vk_q : '0;
    assign imm_out = en ? imm_q : '0;
    assign pc_out  = en ? pc_q : '0;
    assign rd_out  = en ? rd_q : '0;

    a_load_free: assert property (@(posedge clk) disable iff (rst) load |-> !busy || own_done)
        else $error("station %0d loaded while busy", own_tag);

endmodule

// ==== issue_ctrl.sv ====
`timescale 1ns/1ps

module issue_ctrl (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [tomasulo_pkg::cls_w-1:0] cls,
    input  logic                           busy_alu1,
    input  logic                           busy_alu2,
    input  logic                           busy_mul1,
    input  logic                           busy_brh1,
    input  logic [tomasulo_pkg::tag_w-1:0] alu_done_tag,
    input  logic [tomasulo_pkg::tag_w-1:0] mul_done_tag,
    input  logic [tomasulo_pkg::tag_w-1:0] jump_done_tag,
    output logic                           issue_en,
    output logic                           load_alu1,
    output logic                           load_alu2,
    output logic                           load_mul1,
    output logic                           load_brh1,
    output logic [tomasulo_pkg::tag_w-1:0] wr_tag
);
    import tomasulo_pkg::*;

    logic free_alu1;
    logic free_alu2;
    logic free_mul1;
    logic free_brh1;
    logic has_free;
    logic branch_stall;

    // A station finishing this cycle can take the next instruction
    assign free_alu1 = !busy_alu1 || alu_done_tag == tag_alu1;
    assign free_alu2 = !busy_alu2 || alu_done_tag == tag_alu2;
    assign free_mul1 = !busy_mul1 || mul_done_tag == tag_mul1;
    assign free_brh1 = !busy_brh1 || jump_done_tag == tag_brh1;

    always_comb begin
        case (cls)
            cls_alu:  has_free = free_alu1 || free_alu2;
            cls_mul:  has_free = free_mul1;
            cls_jump: has_free = free_brh1;
            default:  has_free = 1'b1;
        endcase
    end

    assign issue_en  = has_free && !branch_stall;
    assign load_alu1 = issue_en && cls == cls_alu && free_alu1;
    assign load_alu2 = issue_en && cls == cls_alu && !free_alu1;
    assign load_mul1 = issue_en && cls == cls_mul;
    assign load_brh1 = issue_en && cls == cls_jump;

    assign wr_tag = load_alu1 ? tag_alu1 :
                    load_alu2 ? tag_alu2 :
                    load_mul1 ? tag_mul1 :
                    load_brh1 ? tag_brh1 : tag_none;

    // Hold issue while a branch is unresolved
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            branch_stall <= 1'b0;
        end else if (load_brh1) begin
            branch_stall <= 1'b1;
        end else if (jump_done_tag != tag_none) begin
            branch_stall <= 1'b0;
        end
    end

    a_load_onehot: assert property (@(posedge clk) disable iff (rst)
        issue_en && cls != cls_none |-> $onehot({load_alu1, load_alu2, load_mul1, load_brh1}))
        else $error("issue did not select exactly one station");

    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        $past(load_brh1) && jump_done_tag == tag_none |->
        !(load_alu1 || load_alu2 || load_mul1 || load_brh1))
        else $error("load while branch outstanding");

endmodule

// ==== tomasulo_ctrl.sv ====
`timescale 1ns/1ps

module tomasulo_ctrl (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [tomasulo_pkg::xlen-1:0]       pc,
    input  logic [tomasulo_pkg::xlen-1:0]       inst,
    input  logic [tomasulo_pkg::xlen-1:0]       imm,
    input  logic [tomasulo_pkg::xlen-1:0]       rs1_val,
    input  logic [tomasulo_pkg::xlen-1:0]       rs2_val,
    input  logic [tomasulo_pkg::tag_w-1:0]      alu_done_tag,
    input  logic [tomasulo_pkg::xlen-1:0]       alu_done_val,
    input  logic [tomasulo_pkg::tag_w-1:0]      mul_done_tag,
    input  logic [tomasulo_pkg::xlen-1:0]       mul_done_val,
    input  logic [tomasulo_pkg::tag_w-1:0]      jump_done_tag,
    input  logic [tomasulo_pkg::xlen-1:0]       jump_done_val,
    output logic                                issue_en,
    output logic [tomasulo_pkg::imm_sel_w-1:0]  imm_sel,
    output logic                                alu1_en,
    output logic [tomasulo_pkg::op_w-1:0]       alu1_op,
    output logic [tomasulo_pkg::xlen-1:0]       alu1_vj,
    output logic [tomasulo_pkg::xlen-1:0]       alu1_vk,
    output logic [tomasulo_pkg::xlen-1:0]       alu1_imm,
    output logic [tomasulo_pkg::xlen-1:0]       alu1_pc,
    output logic [tomasulo_pkg::reg_addr_w-1:0] alu1_rd,
    output logic                                alu2_en,
    output logic [tomasulo_pkg::op_w-1:0]       alu2_op,
    output logic [tomasulo_pkg::xlen-1:0]       alu2_vj,
    output logic [tomasulo_pkg::xlen-1:0]       alu2_vk,
    output logic [tomasulo_pkg::xlen-1:0]       alu2_imm,
    output logic [tomasulo_pkg::xlen-1:0]       alu2_pc,
    output logic [tomasulo_pkg::reg_addr_w-1:0] alu2_rd,
    output logic                                mul1_en,
    output logic [tomasulo_pkg::op_w-1:0]       mul1_op,
    output logic [tomasulo_pkg::xlen-1:0]       mul1_vj,
    output logic [tomasulo_pkg::xlen-1:0]       mul1_vk,
    output logic [tomasulo_pkg::reg_addr_w-1:0] mul1_rd,
    output logic                                brh1_en,
    output logic [tomasulo_pkg::op_w-1:0]       brh1_op,
    output logic [tomasulo_pkg::xlen-1:0]       brh1_vj,
    output logic [tomasulo_pkg::xlen-1:0]       brh1_vk,
    output logic [tomasulo_pkg::xlen-1:0]       brh1_imm,
    output logic [tomasulo_pkg::xlen-1:0]       brh1_pc,
    output logic [tomasulo_pkg::reg_addr_w-1:0] brh1_rd
);
    import tomasulo_pkg::*;

    logic [cls_w-1:0]      cls;
    logic [op_w-1:0]       op;
    logic [reg_addr_w-1:0] dst;
    logic [reg_addr_w-1:0] src1;
    logic [reg_addr_w-1:0] src2;
    logic [tag_w-1:0]      q1;
    logic [tag_w-1:0]      q2;
    logic [tag_w-1:0]      wr_tag;
    logic                  load_alu1;
    logic                  load_alu2;
    logic                  load_mul1;
    logic                  load_brh1;
    logic                  busy_alu1;
    logic                  busy_alu2;
    logic                  busy_mul1;
    logic                  busy_brh1;

    inst_decoder u_dec (
        .inst(inst), .cls(cls), .op(op), .dst(dst), .src1(src1), .src2(src2),
        .imm_sel(imm_sel)
    );

    reg_status_table u_rst (
        .clk(clk), .rst(rst), .src1(src1), .src2(src2), .dst(dst), .wr_tag(wr_tag),
        .wr_en(load_alu1 | load_alu2 | load_mul1 | load_brh1),
        .alu_done_tag(alu_done_tag), .mul_done_tag(mul_done_tag),
        .jump_done_tag(jump_done_tag), .q1(q1), .q2(q2)
    );

    issue_ctrl u_iss (
        .clk(clk), .rst(rst), .cls(cls),
        .busy_alu1(busy_alu1), .busy_alu2(busy_alu2),
        .busy_mul1(busy_mul1), .busy_brh1(busy_brh1),
        .alu_done_tag(alu_done_tag), .mul_done_tag(mul_done_tag),
        .jump_done_tag(jump_done_tag), .issue_en(issue_en),
        .load_alu1(load_alu1), .load_alu2(load_alu2),
        .load_mul1(load_mul1), .load_brh1(load_brh1), .wr_tag(wr_tag)
    );

    res_station #(.own_tag(tag_alu1)) u_alu1 (
        .clk(clk), .rst(rst), .load(load_alu1), .op(op), .q1(q1), .q2(q2),
        .rs1_val(rs1_val), .rs2_val(rs2_val), .imm(imm), .pc(pc), .rd(dst),
        .alu_done_tag(alu_done_tag), .alu_done_val(alu_done_val),
        .mul_done_tag(mul_done_tag), .mul_done_val(mul_done_val),
        .jump_done_tag(jump_done_tag), .jump_done_val(jump_done_val),
        .busy(busy_alu1), .en(alu1_en), .op_out(alu1_op), .vj(alu1_vj), .vk(alu1_vk),
        .imm_out(alu1_imm), .pc_out(alu1_pc), .rd_out(alu1_rd)
    );

    res_station #(.own_tag(tag_alu2)) u_alu2 (
        .clk(clk), .rst(rst), .load(load_alu2), .op(op), .q1(q1), .q2(q2),
        .rs1_val(rs1_val), .rs2_val(rs2_val), .imm(imm), .pc(pc), .rd(dst),
        .alu_done_tag(alu_done_tag), .alu_done_val(alu_done_val),
        .mul_done_tag(mul_done_tag), .mul_done_val(mul_done_val),
        .jump_done_tag(jump_done_tag), .jump_done_val(jump_done_val),
        .busy(busy_alu2), .en(alu2_en), .op_out(alu2_op), .vj(alu2_vj), .vk(alu2_vk),
        .imm_out(alu2_imm), .pc_out(alu2_pc), .rd_out(alu2_rd)
    );

    // The multiplier needs neither immediate nor PC
    res_station #(.own_tag(tag_mul1)) u_mul1 (
        .clk(clk), .rst(rst), .load(load_mul1), .op(op), .q1(q1), .q2(q2),
        .rs1_val(rs1_val), .rs2_val(rs2_val), .imm(imm), .pc(pc), .rd(dst),
        .alu_done_tag(alu_done_tag), .alu_done_val(alu_done_val),
        .mul_done_tag(mul_done_tag), .mul_done_val(mul_done_val),
        .jump_done_tag(jump_done_tag), .jump_done_val(jump_done_val),
        .busy(busy_mul1), .en(mul1_en), .op_out(mul1_op), .vj(mul1_vj), .vk(mul1_vk),
        .imm_out(), .pc_out(), .rd_out(mul1_rd)
    );

    res_station #(.own_tag(tag_brh1)) u_brh1 (
        .clk(clk), .rst(rst), .load(load_brh1), .op(op), .q1(q1), .q2(q2),
        .rs1_val(rs1_val), .rs2_val(rs2_val), .imm(imm), .pc(pc), .rd(dst),
        .alu_done_tag(alu_done_tag), .alu_done_val(alu_done_val),
        .mul_done_tag(mul_done_tag), .mul_done_val(mul_done_val),
        .jump_done_tag(jump_done_tag), .jump_done_val(jump_done_val),
        .busy(busy_brh1), .en(brh1_en), .op_out(brh1_op), .vj(brh1_vj), .vk(brh1_vk),
        .imm_out(brh1_imm), .pc_out(brh1_pc), .rd_out(brh1_rd)
    );

endmodule

// ==== tb_tomasulo_ctrl.sv ====
`timescale 1ns/1ps

module tb_tomasulo_ctrl;
    import tomasulo_pkg::*;

    // Directed tests take about 40 cycles, so this leaves a wide margin
    localparam int max_cycles = 200;

    logic clk;
    logic rst;
    logic [xlen-1:0] pc, inst, imm, rs1_val, rs2_val;
    logic [tag_w-1:0] alu_done_tag, mul_done_tag, jump_done_tag;
    logic [xlen-1:0] alu_done_val, mul_done_val, jump_done_val;
    logic issue_en;
    logic [imm_sel_w-1:0] imm_sel;
    logic alu1_en, alu2_en, mul1_en, brh1_en;
    logic [op_w-1:0] alu1_op, alu2_op, mul1_op, brh1_op;
    logic [xlen-1:0] alu1_vj, alu1_vk, alu1_imm, alu1_pc;
    logic [xlen-1:0] alu2_vj, alu2_vk, alu2_imm, alu2_pc;
    logic [xlen-1:0] mul1_vj, mul1_vk;
    logic [xlen-1:0] brh1_vj, brh1_vk, brh1_imm, brh1_pc;
    logic [reg_addr_w-1:0] alu1_rd, alu2_rd, mul1_rd, brh1_rd;

    // Check enables, set for the coming edge only
    logic chk_idle, chk_issue, chk_stall, chk_wait, chk_alu1, chk_alu2, chk_brh;
    logic chk_mul, chk_sel;
    logic [op_w-1:0] exp1_op, exp2_op;
    logic [xlen-1:0] exp1_vj, exp1_vk, exp2_vj, exp2_vk;
    logic [xlen-1:0] exp1_imm, exp1_pc, exp2_imm, exp2_pc;
    logic [xlen-1:0] exp_m_vj, exp_m_vk;
    logic [xlen-1:0] exp_b_vj, exp_b_vk, exp_b_imm, exp_b_pc;
    logic [reg_addr_w-1:0] exp1_rd, exp2_rd, exp_m_rd;
    logic [imm_sel_w-1:0] exp_sel;

    integer seed;
    int err_count, err_mark, pass_count, fail_count, cycle_count;

    tomasulo_ctrl dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [4:0] rd);
        return {f7, rs2, rs1, 3'd0, rd, opc_r};
    endfunction

    function automatic logic [31:0] b_type(input logic [4:0] rs2, input logic [4:0] rs1);
        return {7'd0, rs2, rs1, 3'd0, 5'd0, opc_b};
    endfunction

    task automatic log_error(input string msg);
        err_count++;
        $display("ERR %0t ns: %s", $time, msg);
    endtask

    task automatic end_test(input string name);
        if (err_count == err_mark) begin
            pass_count++;
            $display("test %-12s ok", name);
        end else begin
            fail_count++;
            $display("test %-12s failed with %0d errors", name, err_count - err_mark);
        end
        err_mark = err_count;
    endtask

    // Next cycle, inputs land 2 ns after the edge
    task automatic tick();
        @(posedge clk);
        #2;
        {chk_idle, chk_issue, chk_stall, chk_wait, chk_alu1, chk_alu2, chk_brh,
         chk_mul, chk_sel} = '0;
        inst          = '0;
        alu_done_tag  = tag_none;
        mul_done_tag  = tag_none;
        jump_done_tag = tag_none;
    endtask

    task automatic drive_inst(input logic [31:0] w);
        inst      = w;
        pc        = pc + 4;
        imm       = $random(seed);
        rs1_val   = $random(seed);
        rs2_val   = $random(seed);
        chk_issue = 1'b1;
        // R-type has no immediate format
        exp_sel   = '0;
        chk_sel   = 1'b1;
    endtask

    a_idle: assert property (@(posedge clk) disable iff (rst) chk_idle |->
        issue_en && !alu1_en && !alu2_en && !mul1_en && !brh1_en)
        else log_error("state after reset is wrong");
    a_issue: assert property (@(posedge clk) disable iff (rst) chk_issue |-> issue_en)
        else log_error("issue_en low where issue was expected");
    a_sel: assert property (@(posedge clk) disable iff (rst) chk_sel |-> imm_sel == exp_sel)
        else log_error("imm_sel differs from expected");
    a_stall: assert property (@(posedge clk) disable iff (rst) chk_stall |-> !issue_en)
        else log_error("issue_en high where a stall was expected");
    a_wait: assert property (@(posedge clk) disable iff (rst) chk_wait |-> !alu1_en)
        else log_error("alu1 enabled before its operand arrived");
    a_alu1: assert property (@(posedge clk) disable iff (rst) chk_alu1 |->
        alu1_en && alu1_op == exp1_op && alu1_vj == exp1_vj &&
        alu1_vk == exp1_vk && alu1_rd == exp1_rd &&
        alu1_imm == exp1_imm && alu1_pc == exp1_pc)
        else log_error("alu1 outputs differ from expected");
    a_alu2: assert property (@(posedge clk) disable iff (rst) chk_alu2 |->
        alu2_en && alu2_op == exp2_op && alu2_vj == exp2_vj &&
        alu2_vk == exp2_vk && alu2_rd == exp2_rd &&
        alu2_imm == exp2_imm && alu2_pc == exp2_pc)
        else log_error("alu2 outputs differ from expected");
    a_mul: assert property (@(posedge clk) disable iff (rst) chk_mul |->
        mul1_en && mul1_op == op_mul_mul && mul1_vj == exp_m_vj &&
        mul1_vk == exp_m_vk && mul1_rd == exp_m_rd)
        else log_error("mul station outputs differ from expected");
    a_brh: assert property (@(posedge clk) disable iff (rst) chk_brh |->
        brh1_en && brh1_op == op_jump_beq && brh1_vj == exp_b_vj &&
        brh1_vk == exp_b_vk && brh1_imm == exp_b_imm && brh1_pc == exp_b_pc &&
        brh1_rd == 5'd0)
        else log_error("branch station outputs differ from expected");

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", max_cycles);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        seed = 81;
        {err_count, err_mark, pass_count, fail_count} = '0;
        {chk_idle, chk_issue, chk_stall, chk_wait, chk_alu1, chk_alu2, chk_brh,
         chk_mul, chk_sel} = '0;
        exp_sel = '0;
        rst = 1'b1;
        {pc, inst, imm, rs1_val, rs2_val} = '0;
        {alu_done_tag, mul_done_tag, jump_done_tag} = '0;
        {alu_done_val, mul_done_val, jump_done_val} = '0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        chk_idle = 1'b1;
        tick();
        end_test("reset");

        // Two independent adds fill both ALU stations
        drive_inst(r_type(7'h00, 5'd3, 5'd2, 5'd1));
        tick();
        {exp1_op, exp1_vj, exp1_vk, exp1_rd} = {op_alu_add, rs1_val, rs2_val, 5'd1};
        {exp1_imm, exp1_pc} = {imm, pc};
        chk_alu1 = 1'b1;
        drive_inst(r_type(7'h00, 5'd7, 5'd6, 5'd4));
        tick();
        {exp2_op, exp2_vj, exp2_vk, exp2_rd} = {op_alu_add, rs1_val, rs2_val, 5'd4};
        {exp2_imm, exp2_pc} = {imm, pc};
        chk_alu2 = 1'b1;
        tick();
        alu_done_tag = tag_alu1;
        tick();
        alu_done_tag = tag_alu2;
        tick();
        end_test("alu_issue");

        // ADD waits on MUL x5, then the same with the bypass
        drive_inst(r_type(7'h01, 5'd9, 5'd8, 5'd5));
        tick();
        {exp_m_vj, exp_m_vk, exp_m_rd} = {rs1_val, rs2_val, 5'd5};
        chk_mul = 1'b1;
        drive_inst(r_type(7'h00, 5'd10, 5'd5, 5'd6));
        tick();
        {exp1_op, exp1_vk, exp1_rd} = {op_alu_add, rs2_val, 5'd6};
        {exp1_imm, exp1_pc} = {imm, pc};
        chk_wait = 1'b1;
        tick();
        chk_wait = 1'b1;
        tick();
        mul_done_tag = tag_mul1;
        mul_done_val = $random(seed);
        exp1_vj      = mul_done_val;
        chk_wait     = 1'b1;
        tick();
        chk_alu1 = 1'b1;
        tick();
        alu_done_tag = tag_alu1;
        tick();
        drive_inst(r_type(7'h01, 5'd9, 5'd8, 5'd5));
        tick();
        drive_inst(r_type(7'h00, 5'd11, 5'd5, 5'd7));
        mul_done_tag = tag_mul1;
        mul_done_val = $random(seed);
        {exp1_op, exp1_vj, exp1_vk, exp1_rd} = {op_alu_add, mul_done_val, rs2_val, 5'd7};
        {exp1_imm, exp1_pc} = {imm, pc};
        tick();
        chk_alu1 = 1'b1;
        tick();
        alu_done_tag = tag_alu1;
        tick();
        end_test("dependency");

        // Both ALU stations wait on a MUL, so a third add stalls
        drive_inst(r_type(7'h01, 5'd9, 5'd8, 5'd5));
        tick();
        drive_inst(r_type(7'h00, 5'd13, 5'd5, 5'd12));
        tick();
        drive_inst(r_type(7'h00, 5'd13, 5'd5, 5'd14));
        tick();
        drive_inst(r_type(7'h00, 5'd17, 5'd16, 5'd15));
        chk_issue = 1'b0;
        chk_stall = 1'b1;
        repeat (2) begin
            tick();
            inst      = r_type(7'h00, 5'd17, 5'd16, 5'd15);
            chk_stall = 1'b1;
        end
        tick();
        inst         = r_type(7'h00, 5'd17, 5'd16, 5'd15);
        alu_done_tag = tag_alu1;
        chk_issue    = 1'b1;
        tick();
        {exp1_op, exp1_vj, exp1_vk, exp1_rd} = {op_alu_add, rs1_val, rs2_val, 5'd15};
        {exp1_imm, exp1_pc} = {imm, pc};
        chk_alu1     = 1'b1;
        mul_done_tag = tag_mul1;
        tick();
        alu_done_tag = tag_alu2;
        tick();
        alu_done_tag = tag_alu1;
        tick();
        end_test("full_stall");

        drive_inst(b_type(5'd19, 5'd18));
        exp_sel = imm_type_b;
        tick();
        {exp_b_vj, exp_b_vk, exp_b_imm, exp_b_pc} = {rs1_val, rs2_val, imm, pc};
        chk_brh   = 1'b1;
        chk_stall = 1'b1;
        tick();
        chk_stall = 1'b1;
        tick();
        jump_done_tag = tag_brh1;
        chk_stall     = 1'b1;
        tick();
        chk_issue = 1'b1;
        tick();
        end_test("branch");

        // Completed producer and x0 readers take the register values
        drive_inst(r_type(7'h00, 5'd12, 5'd5, 5'd20));
        tick();
        {exp1_op, exp1_vj, exp1_vk, exp1_rd} = {op_alu_add, rs1_val, rs2_val, 5'd20};
        {exp1_imm, exp1_pc} = {imm, pc};
        chk_alu1 = 1'b1;
        tick();
        alu_done_tag = tag_alu1;
        tick();
        drive_inst(r_type(7'h01, 5'd9, 5'd8, 5'd0));
        tick();
        drive_inst(r_type(7'h00, 5'd0, 5'd0, 5'd21));
        tick();
        {exp1_op, exp1_vj, exp1_vk, exp1_rd} = {op_alu_add, rs1_val, rs2_val, 5'd21};
        {exp1_imm, exp1_pc} = {imm, pc};
        chk_alu1 = 1'b1;
        tick();
        mul_done_tag = tag_mul1;
        alu_done_tag = tag_alu1;
        tick();
        end_test("no_rename");

        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 pass_count, fail_count, err_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
tomasulo_pkg.sv
inst_decoder.sv
reg_status_table.sv
res_station.sv
issue_ctrl.sv
tomasulo_ctrl.sv
tb_tomasulo_ctrl.sv
